/* common/cp0_cfg.svh */
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

`default_nettype none

// entries in the tlb array
`define CP0_TLBNUM 16

// register numbers, select 0 only
`define CP0_INDEX_NUM     0
`define CP0_ENTRYLO0_NUM  2
`define CP0_ENTRYLO1_NUM  3
`define CP0_BADVADDR_NUM  8
`define CP0_COUNT_NUM     9
`define CP0_ENTRYHI_NUM   10
`define CP0_COMPARE_NUM   11
`define CP0_STATUS_NUM    12
`define CP0_CAUSE_NUM     13
`define CP0_EPC_NUM       14

`default_nettype wire

`endif

/* common/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

	typedef logic [31:0] word_t;
	typedef logic [7:0] cp0_addr_t;

	// int, fetch ade, load ade, store ade, sys, bp, ri, ov
	typedef logic [7:0] exc_vec_t;
	typedef logic [5:0] int_vec_t;

	// vpn2, asid, g, pfn0/c/d/v, pfn1/c/d/v
	typedef logic [77:0] tlb_entry_t;

	typedef logic [1:0] tlb_op_t;
	localparam tlb_op_t op_probe = 2'd1;
	localparam tlb_op_t op_read  = 2'd2;
	localparam tlb_op_t op_write = 2'd3;

	typedef enum logic [1:0] {
		st_idle,
		st_exec,
		st_ack
	} tlb_state_t;

endpackage

`default_nettype wire

/* cp0/cp0_regs.sv */
`include "cp0_cfg.svh"
`default_nettype none

module cp0_regs
	import cp0_pkg::*;
#(
	parameter int tlb_num = `CP0_TLBNUM
) (
	input  logic                       clk,
	input  logic                       rst,
	input  cp0_addr_t                  addr,
	input  logic                       wen,
	input  word_t                      wdata,
	input  exc_vec_t                   exc,
	input  word_t                      pc,
	input  logic                       is_slot,
	input  word_t                      bad_vaddr,
	input  int_vec_t                   int_lines,
	input  logic                       eret,
	input  logic                       probe_wen,
	input  word_t                      probe_index,
	input  logic                       read_wen,
	input  tlb_entry_t                 read_entry,
	output word_t                      rdata,
	output word_t                      epc,
	output logic                       int_happen,
	output word_t                      entryhi,
	output logic [$clog2(tlb_num)-1:0] index,
	output tlb_entry_t                 wr_entry
);
	localparam int iw = $clog2(tlb_num);

	logic [31:0] reg_sel;
	logic exc_int, exc_fetch, exc_load, exc_store, exc_sys, exc_bp, exc_ri, exc_ov;
	logic any_exc;
	logic exc_take;
	logic [4:0] exccode;

	logic [7:0] status_im;
	logic status_exl;
	logic status_ie;
	logic cause_bd;
	logic cause_ti;
	logic [7:0] cause_ip;
	logic [4:0] cause_exccode;
	word_t badvaddr_r;
	logic [32:0] count_r;
	word_t compare_r;
	logic index_p;
	logic [iw-1:0] index_val;
	logic [18:0] entryhi_vpn2;
	logic [7:0] entryhi_asid;
	logic [25:0] entrylo0_r;
	logic [25:0] entrylo1_r;
	word_t status_val;
	word_t cause_val;
	word_t index_full;

	// one-hot register select, select field must be 0
	assign reg_sel = (addr[2:0] == 3'd0) ? (32'd1 << addr[7:3]) : 32'd0;

	assign status_val = {9'd0, 1'b1, 6'd0, status_im, 6'd0, status_exl, status_ie};
	assign cause_val  = {cause_bd, cause_ti, 14'd0, cause_ip, 1'b0, cause_exccode, 2'b00};
	assign index_full = {index_p, {(31 - iw){1'b0}}, index_val};
	assign entryhi    = {entryhi_vpn2, 5'd0, entryhi_asid};

	assign rdata = {32{reg_sel[`CP0_INDEX_NUM]}}    & index_full
	             | {32{reg_sel[`CP0_ENTRYLO0_NUM]}} & {6'd0, entrylo0_r}
	             | {32{reg_sel[`CP0_ENTRYLO1_NUM]}} & {6'd0, entrylo1_r}
	             | {32{reg_sel[`CP0_BADVADDR_NUM]}} & badvaddr_r
	             | {32{reg_sel[`CP0_COUNT_NUM]}}    & count_r[32:1]
	             | {32{reg_sel[`CP0_ENTRYHI_NUM]}}  & entryhi
	             | {32{reg_sel[`CP0_COMPARE_NUM]}}  & compare_r
	             | {32{reg_sel[`CP0_STATUS_NUM]}}   & status_val
	             | {32{reg_sel[`CP0_CAUSE_NUM]}}    & cause_val
	             | {32{reg_sel[`CP0_EPC_NUM]}}      & epc;

	assign {exc_int, exc_fetch, exc_load, exc_store, exc_sys, exc_bp, exc_ri, exc_ov} = exc;
	assign any_exc  = |exc;
	assign exc_take = any_exc && !status_exl;

	// fixed priority, address errors share code 4 except the store
	assign exccode = exc_int   ? 5'h00 :
	                 exc_fetch ? 5'h04 :
	                 exc_ri    ? 5'h0a :
	                 exc_sys   ? 5'h08 :
	                 exc_bp    ? 5'h09 :
	                 exc_ov    ? 5'h0c :
	                 exc_load  ? 5'h04 : 5'h05;

	assign int_happen = !status_exl && status_ie && (|(status_im & cause_ip));

	always_ff @(posedge clk) begin
		if (rst) begin
			status_im  <= 8'd0;
			status_ie  <= 1'b0;
			status_exl <= 1'b0;
		end else begin
			if (wen && reg_sel[`CP0_STATUS_NUM]) begin
				status_im <= wdata[15:8];
				status_ie <= wdata[0];
			end
			if (any_exc)
				status_exl <= 1'b1;
			else if (eret)
				status_exl <= 1'b0;
			else if (wen && reg_sel[`CP0_STATUS_NUM])
				status_exl <= wdata[1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cause_bd      <= 1'b0;
			cause_exccode <= 5'd0;
			cause_ti      <= 1'b0;
			cause_ip      <= 8'd0;
		end else begin
			if (exc_take) begin
				cause_bd      <= is_slot;
				cause_exccode <= exccode;
			end
			if (wen && reg_sel[`CP0_COMPARE_NUM])
				cause_ti <= 1'b0;
			else if (count_r[32:1] == compare_r)
				cause_ti <= 1'b1;
			// timer shares ip7 with the top hardware line
			cause_ip[7:2] <= {int_lines[5] | cause_ti, int_lines[4:0]};
			if (wen && reg_sel[`CP0_CAUSE_NUM])
				cause_ip[1:0] <= wdata[9:8];
		end
	end

	always_ff @(posedge clk) begin
		if (exc_take)
			epc <= is_slot ? pc - 32'd4 : pc;
		else if (wen && reg_sel[`CP0_EPC_NUM])
			epc <= wdata;
		if (exc_fetch || exc_load || exc_store)
			badvaddr_r <= bad_vaddr;
	end

	// count runs at half the clock rate
	always_ff @(posedge clk) begin
		if (rst)
			count_r <= 33'd0;
		else if (wen && reg_sel[`CP0_COUNT_NUM])
			count_r <= {wdata, 1'b0};
		else
			count_r <= count_r + 33'd1;
		if (rst)
			compare_r <= 32'hffff_ffff;
		else if (wen && reg_sel[`CP0_COMPARE_NUM])
			compare_r <= wdata;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			index_p   <= 1'b0;
			index_val <= '0;
		end else if (probe_wen) begin
			index_p   <= probe_index[31];
			index_val <= probe_index[iw-1:0];
		end else if (wen && reg_sel[`CP0_INDEX_NUM]) begin
			index_val <= wdata[iw-1:0];
		end
	end

	// staging registers, tlbr result wins over software
	always_ff @(posedge clk) begin
		if (read_wen) begin
			entryhi_vpn2 <= read_entry[77:59];
			entryhi_asid <= read_entry[58:51];
			entrylo0_r   <= {read_entry[49:25], read_entry[50]};
			entrylo1_r   <= {read_entry[24:0], read_entry[50]};
		end else if (wen) begin
			if (reg_sel[`CP0_ENTRYHI_NUM]) begin
				entryhi_vpn2 <= wdata[31:13];
				entryhi_asid <= wdata[7:0];
			end
			if (reg_sel[`CP0_ENTRYLO0_NUM])
				entrylo0_r <= wdata[25:0];
			if (reg_sel[`CP0_ENTRYLO1_NUM])
				entrylo1_r <= wdata[25:0];
		end
	end

	assign index = index_val;
	assign wr_entry = {entryhi_vpn2, entryhi_asid, entrylo0_r[0] & entrylo1_r[0],
	                   entrylo0_r[25:1], entrylo1_r[25:1]};

endmodule

`default_nettype wire

/* tlb/tlb_array.sv */
`include "cp0_cfg.svh"
`default_nettype none

module tlb_array
	import cp0_pkg::*;
#(
	parameter int tlb_num = `CP0_TLBNUM
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       tlb_req,
	input  tlb_op_t                    tlb_op,
	input  word_t                      entryhi,
	input  logic [$clog2(tlb_num)-1:0] index,
	input  tlb_entry_t                 wr_entry,
	output logic                       tlb_ack,
	output logic                       probe_wen,
	output word_t                      probe_index,
	output logic                       read_wen,
	output tlb_entry_t                 read_entry
);
	localparam int iw = $clog2(tlb_num);

	tlb_state_t state;
	tlb_entry_t entries [tlb_num];
	logic found;
	logic [iw-1:0] hit_slot;
	logic write_en;

	// four-phase handshake, one cycle in exec per request
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= st_idle;
			tlb_ack <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (tlb_req)
						state <= st_exec;
				end
				st_exec: begin
					state   <= st_ack;
					tlb_ack <= 1'b1;
				end
				st_ack: begin
					if (!tlb_req) begin
						state   <= st_idle;
						tlb_ack <= 1'b0;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign probe_wen = (state == st_exec) && (tlb_op == op_probe);
	assign read_wen  = (state == st_exec) && (tlb_op == op_read);
	assign write_en  = (state == st_exec) && (tlb_op == op_write);

	// scan downward so the lowest matching slot is kept
	always_comb begin
		found    = 1'b0;
		hit_slot = '0;
		for (int i = tlb_num - 1; i >= 0; i--) begin
			if (entries[i][77:59] == entryhi[31:13] &&
			    (entries[i][50] || entries[i][58:51] == entryhi[7:0])) begin
				found    = 1'b1;
				hit_slot = iw'(i);
			end
		end
	end

	assign probe_index = {~found, {(31 - iw){1'b0}}, hit_slot};
	assign read_entry  = entries[index];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < tlb_num; i++)
				entries[i] <= '0;
		end else if (write_en) begin
			entries[index] <= wr_entry;
		end
	end

endmodule

`default_nettype wire

/* design/cp0_tlb_top.sv */
`include "cp0_cfg.svh"
`default_nettype none

module cp0_tlb_top
	import cp0_pkg::*;
#(
	parameter int tlb_num = `CP0_TLBNUM
) (
	input  logic      clk,
	input  logic      rst,
	input  cp0_addr_t addr,
	input  logic      wen,
	input  word_t     wdata,
	input  exc_vec_t  exc,
	input  word_t     pc,
	input  logic      is_slot,
	input  word_t     bad_vaddr,
	input  int_vec_t  int_lines,
	input  logic      eret,
	output word_t     rdata,
	output word_t     epc,
	output logic      int_happen,
	input  logic      tlb_req,
	input  tlb_op_t   tlb_op,
	output logic      tlb_ack
);
	word_t entryhi;
	logic [$clog2(tlb_num)-1:0] index;
	tlb_entry_t wr_entry;
	logic probe_wen;
	word_t probe_index;
	logic read_wen;
	tlb_entry_t read_entry;

	cp0_regs #(.tlb_num(tlb_num)) cp0_regs_inst (
		.clk, .rst, .addr, .wen, .wdata, .exc, .pc, .is_slot, .bad_vaddr,
		.int_lines, .eret, .probe_wen, .probe_index, .read_wen, .read_entry,
		.rdata, .epc, .int_happen, .entryhi, .index, .wr_entry
	);

	tlb_array #(.tlb_num(tlb_num)) tlb_array_inst (
		.clk, .rst, .tlb_req, .tlb_op, .entryhi, .index, .wr_entry,
		.tlb_ack, .probe_wen, .probe_index, .read_wen, .read_entry
	);

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
	parameter int period = 100
) (
	output logic clk
);
	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

/* sim/tb_checker.sv */
`include "cp0_cfg.svh"
`default_nettype none

module tb_checker
	import cp0_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  cp0_addr_t addr,
	input  logic      wen,
	input  word_t     wdata,
	input  exc_vec_t  exc,
	input  word_t     pc,
	input  logic      is_slot,
	input  word_t     bad_vaddr,
	input  int_vec_t  int_lines,
	input  logic      eret,
	input  logic      tlb_req,
	input  tlb_op_t   tlb_op,
	input  word_t     rdata,
	input  word_t     epc,
	input  logic      int_happen,
	input  logic      tlb_ack,
	input  logic      sample,
	output int        errors
);
	localparam int iw = $clog2(`CP0_TLBNUM);

	logic [7:0] m_im;
	logic m_ie;
	logic m_exl;
	logic m_bd;
	logic m_ti;
	logic [7:0] m_ip;
	logic [4:0] m_code;
	word_t m_epc;
	word_t m_badv;
	word_t m_cmp;
	logic [32:0] m_cnt;
	logic m_p;
	logic [iw-1:0] m_idx;
	logic [18:0] m_vpn;
	logic [7:0] m_asid;
	logic [25:0] m_lo0;
	logic [25:0] m_lo1;
	tlb_entry_t m_tlb [`CP0_TLBNUM];
	logic [1:0] m_st;
	logic m_ack;
	logic m_epc_valid;
	logic m_badv_valid;

	initial errors = 0;

	// priority: int, fetch, ri, sys, bp, ov, load, store
	function automatic logic [4:0] exc_code(exc_vec_t e);
		if (e[7]) return 5'd0;
		if (e[6]) return 5'd4;
		if (e[1]) return 5'd10;
		if (e[3]) return 5'd8;
		if (e[2]) return 5'd9;
		if (e[0]) return 5'd12;
		if (e[5]) return 5'd4;
		return 5'd5;
	endfunction

	function automatic logic wr_to(int num);
		return wen && addr == cp0_addr_t'(num * 8);
	endfunction

	function automatic logic int_rule();
		return !m_exl && m_ie && (|(m_im & m_ip));
	endfunction

	function automatic word_t model_read(cp0_addr_t a);
		if (a[2:0] != 3'd0)
			return '0;
		case (int'(a[7:3]))
			`CP0_INDEX_NUM:    return {m_p, {(31 - iw){1'b0}}, m_idx};
			`CP0_ENTRYLO0_NUM: return {6'd0, m_lo0};
			`CP0_ENTRYLO1_NUM: return {6'd0, m_lo1};
			`CP0_BADVADDR_NUM: return m_badv;
			`CP0_COUNT_NUM:    return m_cnt[32:1];
			`CP0_ENTRYHI_NUM:  return {m_vpn, 5'd0, m_asid};
			`CP0_COMPARE_NUM:  return m_cmp;
			`CP0_STATUS_NUM:   return {9'd0, 1'b1, 6'd0, m_im, 6'd0, m_exl, m_ie};
			`CP0_CAUSE_NUM:    return {m_bd, m_ti, 14'd0, m_ip, 1'b0, m_code, 2'b00};
			`CP0_EPC_NUM:      return m_epc;
			default:           return '0;
		endcase
	endfunction

	// lowest slot whose vpn2 matches and is global or same asid
	function automatic word_t probe_search();
		for (int i = 0; i < `CP0_TLBNUM; i++) begin
			if (m_tlb[i][77:59] == m_vpn && (m_tlb[i][50] || m_tlb[i][58:51] == m_asid))
				return word_t'(i);
		end
		return 32'h8000_0000;
	endfunction

	function automatic tlb_entry_t make_entry();
		return {m_vpn, m_asid, m_lo0[0] & m_lo1[0], m_lo0[25:1], m_lo1[25:1]};
	endfunction

	task automatic report_mismatch(input string name, input word_t exp, input word_t act);
		$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
		errors++;
	endtask

	task automatic advance_model();
		word_t pr;
		tlb_entry_t ent;
		tlb_entry_t rd;
		logic [iw-1:0] old_idx;
		logic old_exl;
		logic old_ti;
		logic [32:0] old_cnt;
		word_t old_cmp;
		pr = probe_search();
		ent = make_entry();
		rd = m_tlb[m_idx];
		old_idx = m_idx;
		old_exl = m_exl;
		old_ti = m_ti;
		old_cnt = m_cnt;
		old_cmp = m_cmp;
		if (wr_to(`CP0_STATUS_NUM)) begin
			m_im = wdata[15:8];
			m_ie = wdata[0];
		end
		if (exc != '0)
			m_exl = 1'b1;
		else if (eret)
			m_exl = 1'b0;
		else if (wr_to(`CP0_STATUS_NUM))
			m_exl = wdata[1];
		if (exc != '0 && !old_exl) begin
			m_bd = is_slot;
			m_code = exc_code(exc);
			m_epc = is_slot ? pc - 32'd4 : pc;
			m_epc_valid = 1'b1;
		end else if (wr_to(`CP0_EPC_NUM)) begin
			m_epc = wdata;
			m_epc_valid = 1'b1;
		end
		if (exc[6] || exc[5] || exc[4]) begin
			m_badv = bad_vaddr;
			m_badv_valid = 1'b1;
		end
		if (wr_to(`CP0_COMPARE_NUM))
			m_ti = 1'b0;
		else if (old_cnt[32:1] == old_cmp)
			m_ti = 1'b1;
		m_ip[7:2] = {int_lines[5] | old_ti, int_lines[4:0]};
		if (wr_to(`CP0_CAUSE_NUM))
			m_ip[1:0] = wdata[9:8];
		m_cnt = wr_to(`CP0_COUNT_NUM) ? {wdata, 1'b0} : old_cnt + 33'd1;
		if (wr_to(`CP0_COMPARE_NUM))
			m_cmp = wdata;
		if (wr_to(`CP0_INDEX_NUM))
			m_idx = wdata[iw-1:0];
		if (wr_to(`CP0_ENTRYHI_NUM)) begin
			m_vpn = wdata[31:13];
			m_asid = wdata[7:0];
		end
		if (wr_to(`CP0_ENTRYLO0_NUM))
			m_lo0 = wdata[25:0];
		if (wr_to(`CP0_ENTRYLO1_NUM))
			m_lo1 = wdata[25:0];
		// a tlb result overrides a software write in the same cycle
		if (m_st == 2'd1) begin
			if (tlb_op == op_probe) begin
				m_p = pr[31];
				m_idx = pr[iw-1:0];
			end else if (tlb_op == op_read) begin
				m_vpn = rd[77:59];
				m_asid = rd[58:51];
				m_lo0 = {rd[49:25], rd[50]};
				m_lo1 = {rd[24:0], rd[50]};
			end else if (tlb_op == op_write) begin
				m_tlb[old_idx] = ent;
			end
		end
		case (m_st)
			2'd0: if (tlb_req) m_st = 2'd1;
			2'd1: begin
				m_st = 2'd2;
				m_ack = 1'b1;
			end
			default: if (!tlb_req) begin
				m_st = 2'd0;
				m_ack = 1'b0;
			end
		endcase
	endtask

	always @(posedge clk) begin
		if (rst) begin
			{m_im, m_ie, m_exl, m_bd, m_ti, m_ip, m_code} = '0;
			m_cmp = 32'hffff_ffff;
			m_cnt = '0;
			m_p = 1'b0;
			m_idx = '0;
			m_st = 2'd0;
			m_ack = 1'b0;
			m_epc_valid = 1'b0;
			m_badv_valid = 1'b0;
			for (int i = 0; i < `CP0_TLBNUM; i++)
				m_tlb[i] = '0;
		end else begin
			if (tlb_ack !== m_ack)
				report_mismatch("tlb_ack", {31'd0, m_ack}, {31'd0, tlb_ack});
			if (int_happen !== int_rule())
				report_mismatch("int_happen", {31'd0, int_rule()}, {31'd0, int_happen});
			if (sample) begin
				if (rdata !== model_read(addr) &&
				    (addr != cp0_addr_t'(`CP0_BADVADDR_NUM * 8) || m_badv_valid))
					report_mismatch("rdata", model_read(addr), rdata);
				if (m_epc_valid && epc !== m_epc)
					report_mismatch("epc", m_epc, epc);
			end
			advance_model();
		end
	end

endmodule

`default_nettype wire

/* sim/cp0_sva.sv */
`default_nettype none

module cp0_sva (
	input logic       clk,
	input logic       rst,
	input logic       tlb_req,
	input logic [1:0] tlb_op,
	input logic       tlb_ack,
	input logic       probe_wen,
	input logic       read_wen,
	input logic       int_happen,
	input logic [5:0] int_lines,
	input logic       ie,
	input logic       exl,
	input logic       ti,
	input logic [7:0] im,
	input logic [1:0] ip_sw
);
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(tlb_ack) |-> $past(tlb_req))
		else $error("tlb_ack rose with no request pending");

	op_stable: assert property (@(posedge clk) disable iff (rst)
		tlb_req && $past(tlb_req) |-> tlb_op == $past(tlb_op))
		else $error("tlb_op changed while tlb_req was high");

	// pending bits rebuilt from the lines and timer one cycle back
	irq_rule: assert property (@(posedge clk) disable iff (rst)
		int_happen == (!exl && ie &&
			(|(im & {$past(int_lines[5]) | $past(ti), $past(int_lines[4:0]), ip_sw}))))
		else $error("int_happen disagrees with status and the delayed interrupt lines");

	probe_pulse: assert property (@(posedge clk) disable iff (rst)
		probe_wen |=> !probe_wen)
		else $error("probe strobe longer than one cycle");

	read_pulse: assert property (@(posedge clk) disable iff (rst)
		read_wen |=> !read_wen)
		else $error("read strobe longer than one cycle");

endmodule

bind cp0_tlb_top cp0_sva cp0_sva_inst (
	.clk, .rst, .tlb_req, .tlb_op, .tlb_ack, .probe_wen, .read_wen, .int_happen,
	.int_lines,
	.ie(cp0_regs_inst.status_ie), .exl(cp0_regs_inst.status_exl),
	.ti(cp0_regs_inst.cause_ti),
	.im(cp0_regs_inst.status_im), .ip_sw(cp0_regs_inst.cause_ip[1:0])
);

`default_nettype wire

/* sim/tb_top.sv */
`include "cp0_cfg.svh"
`default_nettype none

module tb_top
	import cp0_pkg::*;
();
	// roughly 600 cycles of tests, generous margin
	localparam int max_cycles = 4000;

	logic clk;
	logic rst;
	cp0_addr_t addr;
	logic wen;
	word_t wdata;
	exc_vec_t exc;
	word_t pc;
	logic is_slot;
	word_t bad_vaddr;
	int_vec_t int_lines;
	logic eret;
	logic tlb_req;
	tlb_op_t tlb_op;
	word_t rdata;
	word_t epc;
	logic int_happen;
	logic tlb_ack;
	logic sample;
	int errors;
	int fails = 0;
	int cycles = 0;
	word_t lfsr_state;
	word_t v;
	word_t rv;

	tb_clk_gen clk_gen_inst (.clk);

	cp0_tlb_top cp0_tlb_top_inst (
		.clk, .rst, .addr, .wen, .wdata, .exc, .pc, .is_slot, .bad_vaddr, .int_lines,
		.eret, .rdata, .epc, .int_happen, .tlb_req, .tlb_op, .tlb_ack
	);

	tb_checker checker_inst (
		.clk, .rst, .addr, .wen, .wdata, .exc, .pc, .is_slot, .bad_vaddr, .int_lines,
		.eret, .tlb_req, .tlb_op, .rdata, .epc, .int_happen, .tlb_ack, .sample, .errors
	);

	// galois lfsr, one step per bit
	function automatic word_t rand_bits(int nbits);
		word_t r;
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic step();
		@(posedge clk);
		#10;
	endtask

	task automatic write_reg(input int num, input word_t data);
		addr = cp0_addr_t'(num * 8);
		wen = 1'b1;
		wdata = data;
		step();
		wen = 1'b0;
	endtask

	task automatic read_reg(input int num);
		addr = cp0_addr_t'(num * 8);
		sample = 1'b1;
		#1 rv = rdata;
		step();
		sample = 1'b0;
	endtask

	task automatic tlb_cmd(input tlb_op_t op);
		int waited;
		waited = 0;
		tlb_req = 1'b1;
		tlb_op = op;
		do begin
			step();
			waited++;
		end while (!tlb_ack && waited < 10);
		if (!tlb_ack) begin
			$display("no acknowledge for tlb request op %0d", op);
			fails++;
		end
		tlb_req = 1'b0;
		waited = 0;
		do begin
			step();
			waited++;
		end while (tlb_ack && waited < 10);
		if (tlb_ack) begin
			$display("tlb acknowledge stayed high after the request dropped");
			fails++;
		end
	endtask

	task automatic test_regs();
		int nums [8] = '{`CP0_STATUS_NUM, `CP0_CAUSE_NUM, `CP0_EPC_NUM, `CP0_COMPARE_NUM,
		                 `CP0_INDEX_NUM, `CP0_ENTRYHI_NUM, `CP0_ENTRYLO0_NUM,
		                 `CP0_ENTRYLO1_NUM};
		for (int r = 0; r < 4; r++) begin
			for (int k = 0; k < 8; k++) begin
				v = rand_bits(32);
				// compare far above count so TI stays clear
				if (nums[k] == `CP0_COMPARE_NUM)
					v[31] = 1'b1;
				write_reg(nums[k], v);
				read_reg(nums[k]);
			end
		end
		write_reg(`CP0_STATUS_NUM, '0);
		write_reg(`CP0_CAUSE_NUM, '0);
	endtask

	task automatic test_exc();
		for (int k = 0; k < 10; k++) begin
			exc = exc_vec_t'(rand_bits(8));
			if (exc == '0)
				exc = 8'h01;
			v = rand_bits(31);
			pc = {v[29:0], 2'b00};
			is_slot = v[30];
			bad_vaddr = rand_bits(32);
			step();
			exc = '0;
			read_reg(`CP0_CAUSE_NUM);
			read_reg(`CP0_EPC_NUM);
			read_reg(`CP0_STATUS_NUM);
			read_reg(`CP0_BADVADDR_NUM);
			// nested syscall must leave epc and bd alone
			exc = 8'h08;
			pc = pc + 32'd64;
			is_slot = ~is_slot;
			step();
			exc = '0;
			read_reg(`CP0_CAUSE_NUM);
			read_reg(`CP0_EPC_NUM);
			eret = 1'b1;
			step();
			eret = 1'b0;
			read_reg(`CP0_STATUS_NUM);
		end
	endtask

	task automatic test_irq();
		for (int k = 0; k < 16; k++) begin
			v = rand_bits(14);
			write_reg(`CP0_STATUS_NUM, {16'd0, 1'b0, v[6:0], 6'd0, 1'b0, v[7]});
			int_lines = v[13:8];
			step();
			step();
			read_reg(`CP0_CAUSE_NUM);
			write_reg(`CP0_STATUS_NUM, {16'd0, 1'b0, v[6:0], 6'd0, 1'b1, v[7]});
			read_reg(`CP0_STATUS_NUM);
		end
		int_lines = '0;
		write_reg(`CP0_STATUS_NUM, '0);
	endtask

	task automatic test_timer();
		int polls;
		polls = 0;
		write_reg(`CP0_STATUS_NUM, 32'h0000_8001);
		read_reg(`CP0_COUNT_NUM);
		write_reg(`CP0_COMPARE_NUM, rv + 32'd3);
		rv = '0;
		while (!rv[30] && polls < 20) begin
			read_reg(`CP0_CAUSE_NUM);
			polls++;
		end
		if (!rv[30]) begin
			$display("timer bit in cause never set after count reached compare");
			fails++;
		end
		if (!int_happen) begin
			$display("timer interrupt did not raise int_happen");
			fails++;
		end
		write_reg(`CP0_COMPARE_NUM, 32'hffff_ffff);
		read_reg(`CP0_CAUSE_NUM);
		if (rv[30]) begin
			$display("timer bit in cause still set after compare was rewritten");
			fails++;
		end
		write_reg(`CP0_STATUS_NUM, '0);
	endtask

	task automatic test_tlb_rw();
		for (int k = 0; k < 3; k++) begin
			write_reg(`CP0_INDEX_NUM, rand_bits(4));
			write_reg(`CP0_ENTRYHI_NUM, rand_bits(32));
			write_reg(`CP0_ENTRYLO0_NUM, rand_bits(32));
			write_reg(`CP0_ENTRYLO1_NUM, rand_bits(32));
			tlb_cmd(op_write);
			write_reg(`CP0_ENTRYHI_NUM, '0);
			write_reg(`CP0_ENTRYLO0_NUM, '0);
			write_reg(`CP0_ENTRYLO1_NUM, '0);
			tlb_cmd(op_read);
			read_reg(`CP0_ENTRYHI_NUM);
			read_reg(`CP0_ENTRYLO0_NUM);
			read_reg(`CP0_ENTRYLO1_NUM);
			read_reg(`CP0_INDEX_NUM);
		end
	endtask

	task automatic test_probe();
		// few vpn2 and asid values so entries collide
		for (int k = 0; k < 8; k++) begin
			write_reg(`CP0_INDEX_NUM, word_t'(k));
			v = rand_bits(4);
			write_reg(`CP0_ENTRYHI_NUM, {17'd0, v[1:0], 5'd0, 6'd0, v[3:2]});
			write_reg(`CP0_ENTRYLO0_NUM, rand_bits(26));
			write_reg(`CP0_ENTRYLO1_NUM, rand_bits(26));
			tlb_cmd(op_write);
		end
		for (int k = 0; k < 12; k++) begin
			v = rand_bits(5);
			write_reg(`CP0_ENTRYHI_NUM, {16'd0, v[2:0], 5'd0, 6'd0, v[4:3]});
			tlb_cmd(op_probe);
			read_reg(`CP0_INDEX_NUM);
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("run timed out after %0d cycles", max_cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		addr = '0;
		wen = 1'b0;
		wdata = '0;
		exc = '0;
		pc = '0;
		is_slot = 1'b0;
		bad_vaddr = '0;
		int_lines = '0;
		eret = 1'b0;
		tlb_req = 1'b0;
		tlb_op = '0;
		sample = 1'b0;
		lfsr_state = 32'h335c;
		repeat (5) @(posedge clk);
		#10 rst = 1'b0;
		test_regs();
		test_exc();
		test_irq();
		test_timer();
		test_tlb_rw();
		test_probe();
		step();
		$display("checker errors %0d, other errors %0d", errors, fails);
		if (errors + fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/cp0_pkg.sv
cp0/cp0_regs.sv
tlb/tlb_array.sv
design/cp0_tlb_top.sv
sim/tb_clk_gen.sv
sim/tb_checker.sv
sim/cp0_sva.sv
sim/tb_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module tb_top -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Test OK$" && exit 0 || exit 1
